// ==== mci_wdt_err.f ====
src/mci_pkg.sv
src/mci_wdt.sv
src/mci_err_capture.sv
src/mci_top.sv
testbench/mci_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mci_tb
FILELIST  := mci_wdt_err.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== testbench/mci_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the watchdog and error block
// LFSR driven stimulus checked against a cycle model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mci_tb
  import mci_pkg::*;
;
  localparam int WDT_W = WDT_W_DEF;
  localparam int AGG_W = AGG_W_DEF;
  localparam int FW_W  = FW_ERR_W_DEF;

  logic core_clk, rst;
  logic timer1_en, timer2_en, timer1_restart, timer2_restart, t1_service, t2_service;
  logic [WDT_W-1:0] timer1_period, timer2_period;
  logic sram_ecc_unc, dmi_axi_collision, mbox0_ecc_unc, mbox1_ecc_unc;
  fatal_src_t fatal_hw_clr, fatal_hw_mask, hw_err_fatal;
  non_fatal_src_t non_fatal_hw_clr, non_fatal_hw_mask, hw_err_non_fatal;
  logic [FW_W-1:0] fatal_fw_code, fatal_fw_mask, non_fatal_fw_code, non_fatal_fw_mask;
  logic [FW_W-1:0] fw_err_fatal, fw_err_non_fatal;
  logic fatal_fw_we, non_fatal_fw_we;
  logic [AGG_W-1:0] fatal_agg, fatal_agg_mask, non_fatal_agg, non_fatal_agg_mask;
  logic t1_timeout, t2_timeout, all_error_fatal, all_error_non_fatal;

  // Model state
  logic [WDT_W-1:0] m_c1, m_c2;
  logic m_to1, m_to2, m_allf, m_alln;
  fatal_src_t m_hwf;
  non_fatal_src_t m_hwn;
  logic [FW_W-1:0] m_codef, m_coden;
  logic [AGG_W-1:0] m_aggf, m_aggn;

  // Stimulus controls
  logic [31:0] lfsr_state;
  logic indep_mode, pet_on, err_on, full_mask, svc1_req, svc2_req;
  int value_errs, timeout_errs;

  mci_top #(.WDT_W(WDT_W), .AGG_W(AGG_W), .FW_ERR_W(FW_W)) UUT (
    .core_clk_i(core_clk), .rst_i(rst),
    .timer1_en_i(timer1_en), .timer2_en_i(timer2_en),
    .timer1_restart_i(timer1_restart), .timer2_restart_i(timer2_restart),
    .t1_service_i(t1_service), .t2_service_i(t2_service),
    .timer1_period_i(timer1_period), .timer2_period_i(timer2_period),
    .sram_ecc_unc_i(sram_ecc_unc), .dmi_axi_collision_i(dmi_axi_collision),
    .fatal_hw_clr_i(fatal_hw_clr), .fatal_hw_mask_i(fatal_hw_mask),
    .fatal_fw_code_i(fatal_fw_code), .fatal_fw_we_i(fatal_fw_we),
    .fatal_fw_mask_i(fatal_fw_mask), .fatal_agg_i(fatal_agg),
    .fatal_agg_mask_i(fatal_agg_mask),
    .mbox0_ecc_unc_i(mbox0_ecc_unc), .mbox1_ecc_unc_i(mbox1_ecc_unc),
    .non_fatal_hw_clr_i(non_fatal_hw_clr), .non_fatal_hw_mask_i(non_fatal_hw_mask),
    .non_fatal_fw_code_i(non_fatal_fw_code), .non_fatal_fw_we_i(non_fatal_fw_we),
    .non_fatal_fw_mask_i(non_fatal_fw_mask), .non_fatal_agg_i(non_fatal_agg),
    .non_fatal_agg_mask_i(non_fatal_agg_mask),
    .t1_timeout_o(t1_timeout), .t2_timeout_o(t2_timeout),
    .hw_err_fatal_o(hw_err_fatal), .hw_err_non_fatal_o(hw_err_non_fatal),
    .fw_err_fatal_o(fw_err_fatal), .fw_err_non_fatal_o(fw_err_non_fatal),
    .all_error_fatal_o(all_error_fatal), .all_error_non_fatal_o(all_error_non_fatal)
  );

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_fatal(input string name, input fatal_src_t exp, input fatal_src_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_non_fatal(input string name, input non_fatal_src_t exp,
                                 input non_fatal_src_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_code(input string name, input logic [FW_W-1:0] exp,
                            input logic [FW_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle model updated with the inputs sampled at the edge
  ////////////////////////////////////////////////////////////

  task automatic model_step();
    logic nmi, en1, en2, pet1, pet2;
    fatal_src_t srcf;
    non_fatal_src_t srcn;
    nmi  = m_to2 & ~timer2_en;
    en1  = timer1_en & ~m_to1;
    en2  = (timer2_en | m_to1) & ~m_to2;
    pet1 = timer1_restart & ~m_to1;
    pet2 = timer2_restart & ~m_to2;
    srcf = {nmi, sram_ecc_unc, dmi_axi_collision};
    srcn = {mbox0_ecc_unc, mbox1_ecc_unc};
    if (rst) begin
      {m_c1, m_c2, m_to1, m_to2, m_allf, m_alln} = '0;
      {m_hwf, m_hwn, m_codef, m_coden, m_aggf, m_aggn} = '0;
    end else begin
      m_allf = |(m_hwf & ~fatal_hw_mask) | |(m_codef & ~fatal_fw_mask)
             | |(m_aggf & ~fatal_agg_mask);
      m_alln = |(m_hwn & ~non_fatal_hw_mask) | |(m_coden & ~non_fatal_fw_mask)
             | |(m_aggn & ~non_fatal_agg_mask);
      m_hwf  = (m_hwf & ~fatal_hw_clr) | srcf;
      m_hwn  = (m_hwn & ~non_fatal_hw_clr) | srcn;
      if (fatal_fw_we) m_codef = fatal_fw_code;
      if (non_fatal_fw_we) m_coden = non_fatal_fw_code;
      m_aggf = fatal_agg;
      m_aggn = non_fatal_agg;
      if (t1_service) begin
        m_c1 = '0;
        m_to1 = 1'b0;
      end else if (pet1) begin
        m_c1 = '0;
      end else if (en1) begin
        if (m_c1 == timer1_period) m_to1 = 1'b1;
        m_c1 = m_c1 + 1;
      end
      if (t2_service) begin
        m_c2 = '0;
        m_to2 = 1'b0;
      end else if (pet2) begin
        m_c2 = '0;
      end else if (en2) begin
        if (m_c2 == timer2_period) m_to2 = 1'b1;
        m_c2 = m_c2 + 1;
      end
    end
  endtask

  // Next cycle's inputs from the current stimulus controls
  task automatic drive_inputs();
    timer1_en      = 1'b1;
    timer2_en      = indep_mode;
    timer1_restart = pet_on && (rand_bits(5) == 0);
    timer2_restart = pet_on && (rand_bits(5) == 0);
    t1_service     = svc1_req;
    t2_service     = svc2_req;
    svc1_req       = 1'b0;
    svc2_req       = 1'b0;
    sram_ecc_unc      = err_on && (rand_bits(3) == 0);
    dmi_axi_collision = err_on && (rand_bits(3) == 0);
    mbox0_ecc_unc     = err_on && (rand_bits(3) == 0);
    mbox1_ecc_unc     = err_on && (rand_bits(3) == 0);
    fatal_hw_clr      = (rand_bits(2) == 0) ? 3'(rand_bits(3)) : '0;
    non_fatal_hw_clr  = (rand_bits(2) == 0) ? 2'(rand_bits(2)) : '0;
    fatal_fw_we       = err_on && (rand_bits(2) == 0);
    non_fatal_fw_we   = err_on && (rand_bits(2) == 0);
    fatal_fw_code     = rand_bits(FW_W);
    non_fatal_fw_code = rand_bits(FW_W);
    fatal_agg         = err_on ? AGG_W'(rand_bits(AGG_W)) : '0;
    non_fatal_agg     = err_on ? AGG_W'(rand_bits(AGG_W)) : '0;
    // Sparse masks leave a useful mix of masked and unmasked sources
    fatal_hw_mask      = full_mask ? '1 : 3'(rand_bits(3));
    non_fatal_hw_mask  = full_mask ? '1 : 2'(rand_bits(2));
    fatal_fw_mask      = full_mask ? '1 : ~(FW_W'(1) << rand_bits(5));
    non_fatal_fw_mask  = full_mask ? '1 : ~(FW_W'(1) << rand_bits(5));
    fatal_agg_mask     = full_mask ? '1 : AGG_W'(rand_bits(AGG_W) | rand_bits(AGG_W));
    non_fatal_agg_mask = full_mask ? '1 : AGG_W'(rand_bits(AGG_W) | rand_bits(AGG_W));
  endtask

  task automatic run_cycle();
    @(posedge core_clk);
    #1;
    model_step();
    check_bit("t1_timeout_o", m_to1, t1_timeout);
    check_bit("t2_timeout_o", m_to2, t2_timeout);
    check_fatal("hw_err_fatal_o", m_hwf, hw_err_fatal);
    check_non_fatal("hw_err_non_fatal_o", m_hwn, hw_err_non_fatal);
    check_code("fw_err_fatal_o", m_codef, fw_err_fatal);
    check_code("fw_err_non_fatal_o", m_coden, fw_err_non_fatal);
    check_bit("all_error_fatal_o", m_allf, all_error_fatal);
    check_bit("all_error_non_fatal_o", m_alln, all_error_non_fatal);
    #4;
    drive_inputs();
  endtask

  // Runs until the timer expires and then services it
  task automatic wait_timeout(input int which);
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 200 && !seen; i++) begin
      run_cycle();
      seen = (which == 1) ? t1_timeout : t2_timeout;
    end
    if (!seen) begin
      $display("Timer %0d timeout never came within 200 cycles", which);
      timeout_errs++;
    end
    if (which == 1) svc1_req = 1'b1;
    else svc2_req = 1'b1;
    run_cycle();
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) run_cycle();
    rst = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr_state = 32'h9779ff92;
    value_errs = 0;
    timeout_errs = 0;
    {indep_mode, pet_on, err_on, full_mask, svc1_req, svc2_req} = '0;
    rst = 1'b1;
    timer1_period = WDT_W'(4 + rand_bits(4));
    timer2_period = WDT_W'(4 + rand_bits(4));
    drive_inputs();
    {m_c1, m_c2, m_to1, m_to2, m_allf, m_alln} = '0;
    {m_hwf, m_hwn, m_codef, m_coden, m_aggf, m_aggn} = '0;
    apply_reset();

    // Independent timers without pets and then with random pets
    indep_mode = 1'b1;
    for (int k = 0; k < 4; k++) begin
      pet_on = (k > 1);
      wait_timeout(1);
      wait_timeout(2);
    end

    // Cascade mode where timer 2 starts only after timer 1 expires
    indep_mode = 1'b0;
    svc1_req = 1'b1;
    svc2_req = 1'b1;
    for (int k = 0; k < 3; k++) begin
      timer2_period = WDT_W'(4 + rand_bits(4));
      wait_timeout(2);
      svc1_req = 1'b1;
      repeat (3) run_cycle();
    end

    // Random error traffic in both classes
    err_on = 1'b1;
    repeat (300) run_cycle();
    full_mask = 1'b1;
    repeat (60) run_cycle();
    full_mask = 1'b0;

    // Reset in mid-run followed by more traffic
    apply_reset();
    repeat (80) run_cycle();

    $display("Errors: %0d value, %0d timeout", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/mci_top.sv ====
////////////////////////////////////////////////////////////
// Management controller watchdog and error block
// Joins the watchdog with the fatal and non-fatal classes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mci_top
  import mci_pkg::*;
#(
  parameter int WDT_W    = WDT_W_DEF,
  parameter int AGG_W    = AGG_W_DEF,
  parameter int FW_ERR_W = FW_ERR_W_DEF
) (
  input  logic                core_clk_i,
  input  logic                rst_i,

  // Watchdog
  input  logic                timer1_en_i,
  input  logic                timer2_en_i,
  input  logic                timer1_restart_i,
  input  logic                timer2_restart_i,
  input  logic                t1_service_i,
  input  logic                t2_service_i,
  input  logic [WDT_W-1:0]    timer1_period_i,
  input  logic [WDT_W-1:0]    timer2_period_i,

  // Fatal class
  input  logic                sram_ecc_unc_i,
  input  logic                dmi_axi_collision_i,
  input  fatal_src_t          fatal_hw_clr_i,
  input  fatal_src_t          fatal_hw_mask_i,
  input  logic [FW_ERR_W-1:0] fatal_fw_code_i,
  input  logic                fatal_fw_we_i,
  input  logic [FW_ERR_W-1:0] fatal_fw_mask_i,
  input  logic [AGG_W-1:0]    fatal_agg_i,
  input  logic [AGG_W-1:0]    fatal_agg_mask_i,

  // Non-fatal class
  input  logic                mbox0_ecc_unc_i,
  input  logic                mbox1_ecc_unc_i,
  input  non_fatal_src_t      non_fatal_hw_clr_i,
  input  non_fatal_src_t      non_fatal_hw_mask_i,
  input  logic [FW_ERR_W-1:0] non_fatal_fw_code_i,
  input  logic                non_fatal_fw_we_i,
  input  logic [FW_ERR_W-1:0] non_fatal_fw_mask_i,
  input  logic [AGG_W-1:0]    non_fatal_agg_i,
  input  logic [AGG_W-1:0]    non_fatal_agg_mask_i,

  output logic                t1_timeout_o,
  output logic                t2_timeout_o,
  output fatal_src_t          hw_err_fatal_o,
  output non_fatal_src_t      hw_err_non_fatal_o,
  output logic [FW_ERR_W-1:0] fw_err_fatal_o,
  output logic [FW_ERR_W-1:0] fw_err_non_fatal_o,
  output logic                all_error_fatal_o,
  output logic                all_error_non_fatal_o
);

  logic           wdt_nmi;
  fatal_src_t     fatal_src;
  non_fatal_src_t non_fatal_src;

  mci_wdt #(
    .WDT_W (WDT_W)
  ) u_wdt (
    .core_clk_i       (core_clk_i),
    .rst_i            (rst_i),
    .timer1_en_i      (timer1_en_i),
    .timer2_en_i      (timer2_en_i),
    .timer1_restart_i (timer1_restart_i),
    .timer2_restart_i (timer2_restart_i),
    .t1_service_i     (t1_service_i),
    .t2_service_i     (t2_service_i),
    .timer1_period_i  (timer1_period_i),
    .timer2_period_i  (timer2_period_i),
    .t1_timeout_o     (t1_timeout_o),
    .t2_timeout_o     (t2_timeout_o),
    .nmi_o            (wdt_nmi)
  );

  // Watchdog NMI is logged as a fatal hardware error
  assign fatal_src.nmi_pin                    = wdt_nmi;
  assign fatal_src.mcu_sram_ecc_unc           = sram_ecc_unc_i;
  assign fatal_src.mcu_sram_dmi_axi_collision = dmi_axi_collision_i;

  assign non_fatal_src.mbox0_ecc_unc = mbox0_ecc_unc_i;
  assign non_fatal_src.mbox1_ecc_unc = mbox1_ecc_unc_i;

  mci_err_capture #(
    .src_t    (fatal_src_t),
    .AGG_W    (AGG_W),
    .FW_ERR_W (FW_ERR_W)
  ) u_err_fatal (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .src_i       (fatal_src),
    .hw_clr_i    (fatal_hw_clr_i),
    .hw_mask_i   (fatal_hw_mask_i),
    .fw_code_i   (fatal_fw_code_i),
    .fw_we_i     (fatal_fw_we_i),
    .fw_mask_i   (fatal_fw_mask_i),
    .agg_i       (fatal_agg_i),
    .agg_mask_i  (fatal_agg_mask_i),
    .hw_err_o    (hw_err_fatal_o),
    .fw_code_o   (fw_err_fatal_o),
    .all_error_o (all_error_fatal_o)
  );

  mci_err_capture #(
    .src_t    (non_fatal_src_t),
    .AGG_W    (AGG_W),
    .FW_ERR_W (FW_ERR_W)
  ) u_err_non_fatal (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .src_i       (non_fatal_src),
    .hw_clr_i    (non_fatal_hw_clr_i),
    .hw_mask_i   (non_fatal_hw_mask_i),
    .fw_code_i   (non_fatal_fw_code_i),
    .fw_we_i     (non_fatal_fw_we_i),
    .fw_mask_i   (non_fatal_fw_mask_i),
    .agg_i       (non_fatal_agg_i),
    .agg_mask_i  (non_fatal_agg_mask_i),
    .hw_err_o    (hw_err_non_fatal_o),
    .fw_code_o   (fw_err_non_fatal_o),
    .all_error_o (all_error_non_fatal_o)
  );

endmodule

// ==== src/mci_err_capture.sv ====
////////////////////////////////////////////////////////////
// Error class capture
// Sticky hardware errors, firmware code, aggregate inputs
// and a masked, registered all-error summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mci_err_capture
  import mci_pkg::*;
#(
  parameter type src_t    = fatal_src_t,
  parameter int  AGG_W    = AGG_W_DEF,
  parameter int  FW_ERR_W = FW_ERR_W_DEF
) (
  input  logic                core_clk_i,
  input  logic                rst_i,
  input  src_t                src_i,
  input  src_t                hw_clr_i,
  input  src_t                hw_mask_i,
  input  logic [FW_ERR_W-1:0] fw_code_i,
  input  logic                fw_we_i,
  input  logic [FW_ERR_W-1:0] fw_mask_i,
  input  logic [AGG_W-1:0]    agg_i,
  input  logic [AGG_W-1:0]    agg_mask_i,
  output src_t                hw_err_o,
  output logic [FW_ERR_W-1:0] fw_code_o,
  output logic                all_error_o
);

  localparam int SRC_W = $bits(src_t);

  logic [SRC_W-1:0]    src_v;
  logic [SRC_W-1:0]    clr_v;
  logic [SRC_W-1:0]    mask_v;
  logic [SRC_W-1:0]    hw_err_q;
  logic [FW_ERR_W-1:0] fw_code_q;
  logic [AGG_W-1:0]    agg_q;
  logic                all_error_q;
  logic                hw_pend;
  logic                fw_pend;
  logic                agg_pend;

  // Flatten the struct ports for per-bit work
  assign src_v  = src_i;
  assign clr_v  = hw_clr_i;
  assign mask_v = hw_mask_i;

  ////////////////////////////////////////////////////////////
  // Error registers
  ////////////////////////////////////////////////////////////

  // A new error in the same cycle as its clear stays set
  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      hw_err_q <= '0;
    end else begin
      hw_err_q <= (hw_err_q & ~clr_v) | src_v;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      fw_code_q <= '0;
    end else if (fw_we_i) begin
      fw_code_q <= fw_code_i;
    end
  end

  // One register stage on the external aggregate levels
  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      agg_q <= '0;
    end else begin
      agg_q <= agg_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // All-error summary
  ////////////////////////////////////////////////////////////

  // Mask bit set means the source is ignored
  assign hw_pend  = |(hw_err_q & ~mask_v);
  assign fw_pend  = |(fw_code_q & ~fw_mask_i);
  assign agg_pend = |(agg_q & ~agg_mask_i);

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      all_error_q <= 1'b0;
    end else begin
      all_error_q <= hw_pend | fw_pend | agg_pend;
    end
  end

  assign hw_err_o    = hw_err_q;
  assign fw_code_o   = fw_code_q;
  assign all_error_o = all_error_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < SRC_W; i++) begin : g_src_chk
    err_src_set_a: assert property (
      @(posedge core_clk_i) disable iff (rst_i)
      src_v[i] |=> hw_err_q[i]
    ) else $error("Hardware error bit %0d not set after source pulse", i);
  end

  // Summary stays quiet for two cycles while the sources refill
  err_all_rst_a: assert property (
    @(posedge core_clk_i)
    $fell(rst_i) |-> (!all_error_q ##1 !all_error_q)
  ) else $error("all_error asserted right after reset");

endmodule

// ==== src/mci_wdt.sv ====
////////////////////////////////////////////////////////////
// Two-timer watchdog
// Cascade or independent mode, pet and service per timer,
// NMI on timer 2 expiry in cascade mode
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mci_wdt
  import mci_pkg::*;
#(
  parameter int WDT_W = WDT_W_DEF
) (
  input  logic             core_clk_i,
  input  logic             rst_i,
  input  logic             timer1_en_i,
  input  logic             timer2_en_i,
  input  logic             timer1_restart_i,
  input  logic             timer2_restart_i,
  input  logic             t1_service_i,
  input  logic             t2_service_i,
  input  logic [WDT_W-1:0] timer1_period_i,
  input  logic [WDT_W-1:0] timer2_period_i,
  output logic             t1_timeout_o,
  output logic             t2_timeout_o,
  output logic             nmi_o
);

  logic [WDT_W-1:0] t1_count_q;
  logic [WDT_W-1:0] t2_count_q;
  logic             t1_timeout_q;
  logic             t2_timeout_q;
  logic             t1_cnt_en;
  logic             t2_cnt_en;
  logic             t1_pet;
  logic             t2_pet;
  logic             t1_hit;
  logic             t2_hit;

  ////////////////////////////////////////////////////////////
  // Count enables and qualified pets
  ////////////////////////////////////////////////////////////

  // A timer freezes once it has expired, until serviced
  assign t1_cnt_en = timer1_en_i & ~t1_timeout_q;

  // Independent mode lets timer 2 run on its own
  // Cascade mode runs it only while timer 1 is expired
  assign t2_cnt_en = (timer2_en_i | t1_timeout_q) & ~t2_timeout_q;

  // Pets have no effect on an expired timer
  assign t1_pet = timer1_restart_i & ~t1_timeout_q;
  assign t2_pet = timer2_restart_i & ~t2_timeout_q;

  assign t1_hit = t1_cnt_en & (t1_count_q == timer1_period_i);
  assign t2_hit = t2_cnt_en & (t2_count_q == timer2_period_i);

  ////////////////////////////////////////////////////////////
  // Timer 1
  ////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      t1_count_q   <= '0;
      t1_timeout_q <= 1'b0;
    end else if (t1_service_i) begin
      t1_count_q   <= '0;
      t1_timeout_q <= 1'b0;
    end else if (t1_pet) begin
      t1_count_q <= '0;
    end else if (t1_cnt_en) begin
      t1_count_q <= t1_count_q + 1'b1;
      if (t1_hit) begin
        t1_timeout_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Timer 2
  ////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      t2_count_q   <= '0;
      t2_timeout_q <= 1'b0;
    end else if (t2_service_i) begin
      t2_count_q   <= '0;
      t2_timeout_q <= 1'b0;
    end else if (t2_pet) begin
      t2_count_q <= '0;
    end else if (t2_cnt_en) begin
      t2_count_q <= t2_count_q + 1'b1;
      if (t2_hit) begin
        t2_timeout_q <= 1'b1;
      end
    end
  end

  assign t1_timeout_o = t1_timeout_q;
  assign t2_timeout_o = t2_timeout_q;

  // Second stage expiry is only an NMI when the timers are chained
  assign nmi_o = t2_timeout_q & ~timer2_en_i;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  wdt_t1_pet_a: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    (timer1_restart_i && !t1_timeout_q) |=> (t1_count_q == '0)
  ) else $error("WDT timer 1 count not cleared by pet");

  wdt_t2_pet_a: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    (timer2_restart_i && !t2_timeout_q) |=> (t2_count_q == '0)
  ) else $error("WDT timer 2 count not cleared by pet");

  wdt_t1_service_a: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    t1_service_i |=> (!t1_timeout_q && (t1_count_q == '0))
  ) else $error("WDT timer 1 timeout not cleared by service");

  wdt_t2_service_a: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    t2_service_i |=> (!t2_timeout_q && (t2_count_q == '0))
  ) else $error("WDT timer 2 timeout not cleared by service");

endmodule

// ==== src/mci_pkg.sv ====
////////////////////////////////////////////////////////////
// Management controller shared definitions
// Default widths for the watchdog and error aggregation,
// and the bit layout of the hardware error sources
////////////////////////////////////////////////////////////

package mci_pkg;

  ////////////////////////////////////////////////////////////
  // Default widths
  ////////////////////////////////////////////////////////////

  // Watchdog counter and period width
  parameter int WDT_W_DEF = 32;

  // External aggregate error inputs per class
  parameter int AGG_W_DEF = 8;

  // Firmware error code register width
  parameter int FW_ERR_W_DEF = 32;

  ////////////////////////////////////////////////////////////
  // Hardware error sources
  ////////////////////////////////////////////////////////////

  // Fatal class with the watchdog NMI in the top bit
  typedef struct packed {
    logic nmi_pin;
    logic mcu_sram_ecc_unc;
    logic mcu_sram_dmi_axi_collision;
  } fatal_src_t;

  // Non-fatal class for uncorrectable ECC in each mailbox SRAM
  typedef struct packed {
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } non_fatal_src_t;

endpackage
